//--- logic/dport_consts.svh
/* Debug port cluster sizing
   Hart count, word width, register map and access latency */

`ifndef DPORT_CONSTS_SVH
`define DPORT_CONSTS_SVH

// Number of harts behind the interconnect
`define DPORT_HART_COUNT 4

// Data and address width of the debug port
`define DPORT_XLEN 64

// General registers per hart, register 0 reads zero
`define DPORT_GPR_COUNT 32

// Read-only status word sits just above the GPRs
`define DPORT_STATUS_ADDR 32

// Accept edge to response valid
`define DPORT_ACCESS_CYCLES 2

`endif

//--- logic/dport_cfg_pkg.sv
/* Sizing types of the debug port cluster */

`default_nettype none

`include "dport_consts.svh"

package dport_cfg_pkg;

    // Index width, at least one bit even for a single hart
    localparam int HART_IDX_W = (`DPORT_HART_COUNT > 1) ? $clog2(`DPORT_HART_COUNT) : 1;

    // Hart select and captured response owner
    typedef logic [HART_IDX_W-1:0] hart_idx_t;

    // One bit per hart
    typedef logic [`DPORT_HART_COUNT-1:0] hart_mask_t;

    // Address, write data and read data
    typedef logic [`DPORT_XLEN-1:0] dport_word_t;

endpackage

`default_nettype wire

//--- logic/dport_proto_pkg.sv
/* Debug request protocol types
   Access type bits, access size and error codes */

`default_nettype none

package dport_proto_pkg;

    // Access type, bit 1 selects a register access
    typedef logic [1:0] dport_type_t;

    localparam int DPORT_TYPE_WRITE_BIT = 0;
    localparam int DPORT_TYPE_REG_BIT   = 1;

    localparam dport_type_t DPORT_TYPE_NOP       = 2'b00;
    localparam dport_type_t DPORT_TYPE_REG_READ  = 2'b10;
    localparam dport_type_t DPORT_TYPE_REG_WRITE = 2'b11;

    // 0..3 for 1, 2, 4, 8 bytes
    typedef logic [2:0] dport_size_t;

    localparam dport_size_t DPORT_SIZE_MAX = 3'd3;

    // Code carried in rdata when resp_error is set
    typedef enum logic [2:0] {
        DPORT_ERR_NONE      = 3'd0,
        DPORT_ERR_RUNNING   = 3'd1,  // Hart not halted
        DPORT_ERR_BAD_ADDR  = 3'd2,
        DPORT_ERR_READ_ONLY = 3'd3,  // Write to status word
        DPORT_ERR_BAD_SIZE  = 3'd4
    } dport_err_t;

endpackage

`default_nettype wire

//--- logic/dport_ic.sv
/* Debug port interconnect
   Fans the request port out to the selected hart, returns the response
   from the hart that accepted the request */

`timescale 1ns/1ps
`default_nettype none

`include "dport_consts.svh"

module dport_ic (
    input  wire logic                          i_clk,
    input  wire logic                          i_nrst,
    // Debug module side
    input  wire dport_cfg_pkg::hart_idx_t      i_hartsel,
    input  wire logic                          i_haltreq,
    input  wire logic                          i_resumereq,
    input  wire logic                          i_resethaltreq,
    input  wire logic                          i_hartreset,
    input  wire logic                          i_req_valid,
    input  wire dport_proto_pkg::dport_type_t  i_req_type,
    input  wire dport_cfg_pkg::dport_word_t    i_addr,
    input  wire dport_cfg_pkg::dport_word_t    i_wdata,
    input  wire dport_proto_pkg::dport_size_t  i_size,
    input  wire logic                          i_resp_ready,
    output logic                               o_req_ready,
    output logic                               o_resp_valid,
    output logic                               o_resp_error,
    output dport_cfg_pkg::dport_word_t         o_rdata,
    // Hart side
    output dport_cfg_pkg::hart_mask_t          o_hart_haltreq,
    output dport_cfg_pkg::hart_mask_t          o_hart_resumereq,
    output dport_cfg_pkg::hart_mask_t          o_hart_resethaltreq,
    output dport_cfg_pkg::hart_mask_t          o_hart_hartreset,
    output dport_cfg_pkg::hart_mask_t          o_hart_req_valid,
    output dport_proto_pkg::dport_type_t       o_hart_req_type,
    output dport_cfg_pkg::dport_word_t         o_hart_addr,
    output dport_cfg_pkg::dport_word_t         o_hart_wdata,
    output dport_proto_pkg::dport_size_t       o_hart_size,
    output logic                               o_hart_resp_ready,
    input  wire dport_cfg_pkg::hart_mask_t     i_hart_req_ready,
    input  wire dport_cfg_pkg::hart_mask_t     i_hart_resp_valid,
    input  wire dport_cfg_pkg::hart_mask_t     i_hart_resp_error,
    input  wire dport_cfg_pkg::dport_word_t    i_hart_rdata [`DPORT_HART_COUNT]
);

    import dport_cfg_pkg::*;

    hart_mask_t sel_mask;     // One-hot of i_hartsel
    hart_idx_t  resp_hart;    // Owner of the outstanding response
    logic       req_accept;

    // Select decode
    always_comb begin
        sel_mask = '0;
        sel_mask[i_hartsel] = 1'b1;
    end

    // Run-control levels reach only the selected hart
    assign o_hart_haltreq      = {`DPORT_HART_COUNT{i_haltreq}} & sel_mask;
    assign o_hart_resumereq    = {`DPORT_HART_COUNT{i_resumereq}} & sel_mask;
    assign o_hart_resethaltreq = {`DPORT_HART_COUNT{i_resethaltreq}} & sel_mask;
    assign o_hart_hartreset    = {`DPORT_HART_COUNT{i_hartreset}} & sel_mask;
    assign o_hart_req_valid    = {`DPORT_HART_COUNT{i_req_valid}} & sel_mask;

    // Request fields are shared, valid does the steering
    assign o_hart_req_type   = i_req_type;
    assign o_hart_addr       = i_addr;
    assign o_hart_wdata      = i_wdata;
    assign o_hart_size       = i_size;
    assign o_hart_resp_ready = i_resp_ready;

    assign o_req_ready = |(i_hart_req_ready & sel_mask);
    assign req_accept  = i_req_valid & o_req_ready;

    // Remember who took the request
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            resp_hart <= '0;
        end else if (req_accept) begin
            resp_hart <= i_hartsel;
        end
    end

    // Response path follows the captured hart, not the live select
    assign o_resp_valid = i_hart_resp_valid[resp_hart];
    assign o_resp_error = i_hart_resp_error[resp_hart];
    assign o_rdata      = i_hart_rdata[resp_hart];

    // Never two harts offered a request at once
    a_single_req_valid: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        $onehot0(o_hart_req_valid)
    );

endmodule

`default_nettype wire

//--- logic/hart_debug_ctrl.sv
/* Debug-side logic of one hart
   Run control, sized register access with error checks, held response */

`timescale 1ns/1ps
`default_nettype none

`include "dport_consts.svh"

module hart_debug_ctrl #(
    parameter int HART_ID = 0
) (
    input  wire logic                          i_clk,
    input  wire logic                          i_nrst,
    input  wire logic                          i_haltreq,
    input  wire logic                          i_resumereq,
    input  wire logic                          i_resethaltreq,
    input  wire logic                          i_hartreset,
    input  wire logic                          i_req_valid,
    input  wire dport_proto_pkg::dport_type_t  i_req_type,
    input  wire dport_cfg_pkg::dport_word_t    i_addr,
    input  wire dport_cfg_pkg::dport_word_t    i_wdata,
    input  wire dport_proto_pkg::dport_size_t  i_size,
    input  wire logic                          i_resp_ready,
    output logic                               o_req_ready,
    output logic                               o_resp_valid,
    output logic                               o_resp_error,
    output dport_cfg_pkg::dport_word_t         o_rdata
);

    import dport_cfg_pkg::*;
    import dport_proto_pkg::*;

    localparam int GPR_IDX_W = $clog2(`DPORT_GPR_COUNT);
    localparam int CNT_W     = $clog2(`DPORT_ACCESS_CYCLES + 1);

    logic                 halted;
    logic                 halt_on_reset;  // Sticky until power-on reset
    dport_word_t          gpr [`DPORT_GPR_COUNT];
    logic                 busy;           // Request held through response
    logic [CNT_W-1:0]     wait_cnt;
    logic                 resp_valid;
    dport_type_t          req_type;
    dport_word_t          req_addr;
    dport_word_t          req_wdata;
    dport_size_t          req_size;
    logic                 req_accept;
    logic                 exec;           // Access resolves on this edge
    logic                 is_reg;
    logic                 is_write;
    logic                 wr_en;
    dport_err_t           acc_err;
    dport_word_t          mask;
    dport_word_t          status_word;
    dport_word_t          rd_value;
    logic [GPR_IDX_W-1:0] gpr_idx;

    // Low bytes kept for a sized access
    function automatic dport_word_t size_mask(input dport_size_t sz);
        int nbits;
        nbits = 8 << sz;
        if (nbits >= `DPORT_XLEN) begin
            return '1;
        end
        return (dport_word_t'(1) << nbits) - dport_word_t'(1);
    endfunction

    assign o_req_ready  = !busy;
    assign o_resp_valid = resp_valid;
    assign req_accept   = i_req_valid && !busy;
    assign exec         = busy && !resp_valid && (wait_cnt == '0);

    assign is_reg   = req_type[DPORT_TYPE_REG_BIT];
    assign is_write = req_type[DPORT_TYPE_WRITE_BIT];
    assign gpr_idx  = req_addr[GPR_IDX_W-1:0];
    assign mask     = size_mask(req_size);

    // First failing check wins
    always_comb begin
        acc_err = DPORT_ERR_NONE;
        if (is_reg) begin
            if (!halted) begin
                acc_err = DPORT_ERR_RUNNING;
            end else if (req_size > DPORT_SIZE_MAX) begin
                acc_err = DPORT_ERR_BAD_SIZE;
            end else if (req_addr > dport_word_t'(`DPORT_STATUS_ADDR)) begin
                acc_err = DPORT_ERR_BAD_ADDR;
            end else if (is_write && req_addr == dport_word_t'(`DPORT_STATUS_ADDR)) begin
                acc_err = DPORT_ERR_READ_ONLY;
            end
        end
    end

    always_comb begin
        status_word = '0;
        status_word[0] = halted;
        status_word[1] = halt_on_reset;
        status_word[15:8] = 8'(HART_ID);
    end

    always_comb begin
        if (req_addr == dport_word_t'(`DPORT_STATUS_ADDR)) begin
            rd_value = status_word;
        end else if (gpr_idx == '0) begin
            rd_value = '0;  // x0 hardwired
        end else begin
            rd_value = gpr[gpr_idx];
        end
    end

    assign wr_en = exec && is_reg && is_write && (acc_err == DPORT_ERR_NONE) && (gpr_idx != '0);

    // Run control and request sequencing
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            halted        <= 1'b0;
            halt_on_reset <= 1'b0;
            busy          <= 1'b0;
            wait_cnt      <= '0;
            resp_valid    <= 1'b0;
        end else begin
            if (i_resethaltreq) begin
                halt_on_reset <= 1'b1;
            end
            if (i_hartreset) begin
                halted <= halt_on_reset;
            end else if (i_haltreq) begin
                halted <= 1'b1;  // Halt beats resume
            end else if (i_resumereq) begin
                halted <= 1'b0;
            end

            if (req_accept) begin
                busy     <= 1'b1;
                wait_cnt <= CNT_W'(`DPORT_ACCESS_CYCLES - 1);
            end else if (exec) begin
                resp_valid <= 1'b1;
            end else if (busy && !resp_valid) begin
                wait_cnt <= wait_cnt - 1'b1;
            end else if (resp_valid && i_resp_ready) begin
                resp_valid <= 1'b0;
                busy       <= 1'b0;
            end
        end
    end

    // Register file cleared by either reset
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < `DPORT_GPR_COUNT; i++) begin
                gpr[i] <= '0;
            end
        end else if (i_hartreset) begin
            for (int i = 0; i < `DPORT_GPR_COUNT; i++) begin
                gpr[i] <= '0;
            end
        end else if (wr_en) begin
            gpr[gpr_idx] <= req_wdata & mask;
        end
    end

    // Request fields and response payload
    always_ff @(posedge i_clk) begin
        if (req_accept) begin
            req_type  <= i_req_type;
            req_addr  <= i_addr;
            req_wdata <= i_wdata;
            req_size  <= i_size;
        end
        if (exec) begin
            o_resp_error <= (acc_err != DPORT_ERR_NONE);
            if (acc_err != DPORT_ERR_NONE) begin
                o_rdata <= dport_word_t'(acc_err);
            end else if (is_reg && !is_write) begin
                o_rdata <= rd_value & mask;
            end else begin
                o_rdata <= '0;  // Writes and no-ops
            end
        end
    end

    a_ready_xor_valid: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        !(o_req_ready && o_resp_valid)
    );

    // Valid rises on the edge `DPORT_ACCESS_CYCLES after accept and is sampled one edge later
    a_access_latency: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        req_accept |=> ##(`DPORT_ACCESS_CYCLES) o_resp_valid
    );

endmodule

`default_nettype wire

//--- logic/dport_cluster.sv
/* Debug port cluster top
   One interconnect in front of a debug controller per hart */

`timescale 1ns/1ps
`default_nettype none

`include "dport_consts.svh"

module dport_cluster (
    input  wire logic                          i_clk,
    input  wire logic                          i_nrst,
    input  wire dport_cfg_pkg::hart_idx_t      i_hartsel,
    input  wire logic                          i_haltreq,
    input  wire logic                          i_resumereq,
    input  wire logic                          i_resethaltreq,
    input  wire logic                          i_hartreset,
    input  wire logic                          i_req_valid,
    input  wire dport_proto_pkg::dport_type_t  i_req_type,
    input  wire dport_cfg_pkg::dport_word_t    i_addr,
    input  wire dport_cfg_pkg::dport_word_t    i_wdata,
    input  wire dport_proto_pkg::dport_size_t  i_size,
    input  wire logic                          i_resp_ready,
    output logic                               o_req_ready,
    output logic                               o_resp_valid,
    output logic                               o_resp_error,
    output dport_cfg_pkg::dport_word_t         o_rdata
);

    import dport_cfg_pkg::*;
    import dport_proto_pkg::*;

    hart_mask_t  hart_haltreq;
    hart_mask_t  hart_resumereq;
    hart_mask_t  hart_resethaltreq;
    hart_mask_t  hart_hartreset;
    hart_mask_t  hart_req_valid;
    dport_type_t hart_req_type;   // Shared by all harts
    dport_word_t hart_addr;
    dport_word_t hart_wdata;
    dport_size_t hart_size;
    logic        hart_resp_ready;
    hart_mask_t  hart_req_ready;
    hart_mask_t  hart_resp_valid;
    hart_mask_t  hart_resp_error;
    dport_word_t hart_rdata [`DPORT_HART_COUNT];

    dport_ic dport_ic_inst (
        .i_clk, .i_nrst, .i_hartsel, .i_haltreq, .i_resumereq, .i_resethaltreq,
        .i_hartreset, .i_req_valid, .i_req_type, .i_addr, .i_wdata, .i_size,
        .i_resp_ready, .o_req_ready, .o_resp_valid, .o_resp_error, .o_rdata,
        .o_hart_haltreq      (hart_haltreq),
        .o_hart_resumereq    (hart_resumereq),
        .o_hart_resethaltreq (hart_resethaltreq),
        .o_hart_hartreset    (hart_hartreset),
        .o_hart_req_valid    (hart_req_valid),
        .o_hart_req_type     (hart_req_type),
        .o_hart_addr         (hart_addr),
        .o_hart_wdata        (hart_wdata),
        .o_hart_size         (hart_size),
        .o_hart_resp_ready   (hart_resp_ready),
        .i_hart_req_ready    (hart_req_ready),
        .i_hart_resp_valid   (hart_resp_valid),
        .i_hart_resp_error   (hart_resp_error),
        .i_hart_rdata        (hart_rdata)
    );

    for (genvar g = 0; g < `DPORT_HART_COUNT; g++) begin : g_hart
        hart_debug_ctrl #(.HART_ID(g)) hart_debug_ctrl_inst (
            .i_clk, .i_nrst,
            .i_haltreq      (hart_haltreq[g]),
            .i_resumereq    (hart_resumereq[g]),
            .i_resethaltreq (hart_resethaltreq[g]),
            .i_hartreset    (hart_hartreset[g]),
            .i_req_valid    (hart_req_valid[g]),
            .i_req_type     (hart_req_type),
            .i_addr         (hart_addr),
            .i_wdata        (hart_wdata),
            .i_size         (hart_size),
            .i_resp_ready   (hart_resp_ready),
            .o_req_ready    (hart_req_ready[g]),
            .o_resp_valid   (hart_resp_valid[g]),
            .o_resp_error   (hart_resp_error[g]),
            .o_rdata        (hart_rdata[g])
        );
    end

endmodule

`default_nettype wire

//--- testbench/tb_dport_tests.svh
/* Directed tests and reference model of the debug port cluster
   Included into the testbench module body */

`ifndef TB_DPORT_TESTS_SVH
`define TB_DPORT_TESTS_SVH

task automatic clear_model();
    for (int h = 0; h < `DPORT_HART_COUNT; h++) begin
        for (int r = 0; r < `DPORT_GPR_COUNT; r++) begin
            model_gpr[h][r] = '0;
        end
        model_halted[h] = 1'b0;
        model_flag[h]   = 1'b0;
    end
endtask

// Bytes kept by an access of 1, 2, 4 or 8 bytes
function automatic dport_word_t size_mask(input dport_size_t s);
    case (s)
        3'd0:    return 64'h0000_0000_0000_00ff;
        3'd1:    return 64'h0000_0000_0000_ffff;
        3'd2:    return 64'h0000_0000_ffff_ffff;
        default: return 64'hffff_ffff_ffff_ffff;
    endcase
endfunction

function automatic dport_word_t status_value(input hart_idx_t h);
    dport_word_t v;
    v = '0;
    v[0]    = model_halted[h];
    v[1]    = model_flag[h];
    v[15:8] = 8'(h);  // Hart index
    return v;
endfunction

// Expected response of one access, model updated for accepted writes
task automatic predict_access(input hart_idx_t h, input dport_type_t t, input dport_word_t a,
                              input dport_word_t d, input dport_size_t s,
                              output logic err, output dport_word_t data);
    dport_err_t code;
    code = DPORT_ERR_NONE;
    if (t[1]) begin
        if (!model_halted[h]) begin
            code = DPORT_ERR_RUNNING;
        end else if (s > 3'd3) begin
            code = DPORT_ERR_BAD_SIZE;
        end else if (a > STATUS) begin
            code = DPORT_ERR_BAD_ADDR;
        end else if (t[0] && a == STATUS) begin
            code = DPORT_ERR_READ_ONLY;
        end
    end
    err  = (code != DPORT_ERR_NONE);
    data = '0;
    if (err) begin
        data = dport_word_t'(code);
    end else if (t[1] && !t[0]) begin
        if (a == STATUS) begin
            data = status_value(h) & size_mask(s);
        end else begin
            data = model_gpr[h][int'(a)] & size_mask(s);
        end
    end else if (t[1] && a != '0) begin
        model_gpr[h][int'(a)] = d & size_mask(s);  // x0 never changes
    end
endtask

// One-cycle run-control pulse to one hart
task automatic pulse_run_control(input hart_idx_t h, input logic halt, input logic resume,
                                 input logic set_flag, input logic reset_hart);
    @(posedge clk);
    hartsel      <= h;
    haltreq      <= halt;
    resumereq    <= resume;
    resethaltreq <= set_flag;
    hartreset    <= reset_hart;
    @(posedge clk);
    haltreq      <= 1'b0;
    resumereq    <= 1'b0;
    resethaltreq <= 1'b0;
    hartreset    <= 1'b0;
    if (reset_hart) begin
        model_halted[h] = model_flag[h];
        for (int r = 0; r < `DPORT_GPR_COUNT; r++) begin
            model_gpr[h][r] = '0;
        end
    end else if (halt) begin
        model_halted[h] = 1'b1;
    end else if (resume) begin
        model_halted[h] = 1'b0;
    end
    if (set_flag) begin
        model_flag[h] = 1'b1;
    end
endtask

task automatic send_request(input hart_idx_t h, input dport_type_t t, input dport_word_t a,
                            input dport_word_t d, input dport_size_t s, output logic accepted);
    int waited;
    waited   = 0;
    accepted = 1'b0;
    @(posedge clk);
    hartsel   <= h;
    req_valid <= 1'b1;
    req_type  <= t;
    addr      <= a;
    wdata     <= d;
    size      <= s;
    while (!accepted && waited < RESP_WAIT) begin
        @(negedge clk);
        if (req_ready) begin
            accepted = 1'b1;
        end else begin
            waited++;
        end
    end
    @(posedge clk);  // Accepting edge
    req_valid <= 1'b0;
    if (!accepted) begin
        report_failure($sformatf("hart %0d did not accept a request within %0d cycles",
                                 h, RESP_WAIT));
    end
endtask

// Cycles counts the edges from accept until resp_valid is seen
task automatic wait_response(output logic answered, output int cycles);
    answered = 1'b0;
    cycles   = 0;
    while (!answered && cycles <= RESP_WAIT) begin
        @(negedge clk);
        if (resp_valid) begin
            answered = 1'b1;
        end else begin
            cycles++;
        end
    end
    if (!answered) begin
        report_failure($sformatf("no response arrived within %0d cycles", RESP_WAIT));
    end
endtask

task automatic run_access(input hart_idx_t h, input dport_type_t t, input dport_word_t a,
                          input dport_word_t d, input dport_size_t s);
    logic        exp_err;
    dport_word_t exp_data;
    logic        accepted;
    logic        answered;
    int          cycles;
    answered = 1'b0;
    predict_access(h, t, a, d, s, exp_err, exp_data);
    send_request(h, t, a, d, s, accepted);
    if (accepted) begin
        wait_response(answered, cycles);
    end
    if (answered) begin
        check_value("latency", dport_word_t'(`DPORT_ACCESS_CYCLES), dport_word_t'(cycles));
        check_value("error flag", dport_word_t'(exp_err), dport_word_t'(resp_error));
        check_value("rdata", exp_data, rdata);
    end
endtask

task automatic test_reset_status();
    hart_idx_t h;
    begin_test("reset_status");
    for (int i = 0; i < `DPORT_HART_COUNT; i++) begin
        h = hart_idx_t'(i);
        run_access(h, TYPE_READ, STATUS, '0, 3'd3);  // Refused while running
        run_access(h, TYPE_READ, dport_word_t'(7), '0, 3'd3);
        run_access(h, TYPE_NOP, '0, '0, 3'd3);
        pulse_run_control(h, 1'b1, 1'b0, 1'b0, 1'b0);
        run_access(h, TYPE_READ, STATUS, '0, 3'd3);
        pulse_run_control(h, 1'b0, 1'b1, 1'b0, 1'b0);
    end
    end_test();
endtask

task automatic test_halt_one();
    begin_test("halt_one");
    pulse_run_control(hart_idx_t'(2), 1'b1, 1'b0, 1'b0, 1'b0);
    for (int i = 0; i < `DPORT_HART_COUNT; i++) begin
        run_access(hart_idx_t'(i), TYPE_READ, STATUS, '0, 3'd3);
    end
    pulse_run_control(hart_idx_t'(2), 1'b0, 1'b1, 1'b0, 1'b0);
    run_access(hart_idx_t'(2), TYPE_READ, STATUS, '0, 3'd3);
    end_test();
endtask

task automatic test_sized_access();
    dport_word_t r;
    dport_size_t ws;
    dport_size_t rs;
    begin_test("sized_access");
    pulse_run_control(hart_idx_t'(1), 1'b1, 1'b0, 1'b0, 1'b0);
    pulse_run_control(hart_idx_t'(3), 1'b1, 1'b0, 1'b0, 1'b0);
    // Background values in hart 3
    for (int i = 0; i < 4; i++) begin
        r = dport_word_t'(1 + rand32() % 31);
        run_access(hart_idx_t'(3), TYPE_WRITE, r, rand64(), 3'd3);
    end
    for (int i = 0; i < 24; i++) begin
        r  = dport_word_t'(rand32() % 32);
        ws = dport_size_t'(rand32() % 4);
        rs = dport_size_t'(rand32() % 4);
        run_access(hart_idx_t'(1), TYPE_WRITE, r, rand64(), ws);
        run_access(hart_idx_t'(1), TYPE_READ, r, '0, rs);
    end
    run_access(hart_idx_t'(1), TYPE_WRITE, '0, rand64(), 3'd3);
    run_access(hart_idx_t'(1), TYPE_READ, '0, '0, 3'd3);
    for (int i = 1; i < `DPORT_GPR_COUNT; i++) begin
        run_access(hart_idx_t'(3), TYPE_READ, dport_word_t'(i), '0, 3'd3);
    end
    end_test();
endtask

task automatic test_access_errors();
    begin_test("access_errors");
    run_access(hart_idx_t'(1), TYPE_READ, dport_word_t'(33), '0, 3'd3);
    run_access(hart_idx_t'(1), TYPE_READ, dport_word_t'(5), '0, 3'd5);
    run_access(hart_idx_t'(1), TYPE_WRITE, STATUS, rand64(), 3'd3);
    run_access(hart_idx_t'(1), TYPE_WRITE, dport_word_t'(33), rand64(), 3'd7);  // Size first
    run_access(hart_idx_t'(1), TYPE_READ, STATUS, '0, 3'd3);
    end_test();
endtask

task automatic test_backpressure();
    dport_word_t r;
    dport_word_t exp_data;
    dport_word_t held;
    logic        exp_err;
    logic        accepted;
    logic        answered;
    int          cycles;
    begin_test("backpressure");
    answered = 1'b0;
    r = dport_word_t'(1 + rand32() % 31);
    run_access(hart_idx_t'(1), TYPE_WRITE, r, rand64(), 3'd3);
    predict_access(hart_idx_t'(1), TYPE_READ, r, '0, 3'd3, exp_err, exp_data);
    @(posedge clk);
    resp_ready <= 1'b0;
    send_request(hart_idx_t'(1), TYPE_READ, r, '0, 3'd3, accepted);
    if (accepted) begin
        wait_response(answered, cycles);
    end
    if (answered) begin
        held = rdata;
        check_value("rdata", exp_data, held);
        repeat (4) begin
            @(negedge clk);
            check_value("held valid", dport_word_t'(1), dport_word_t'(resp_valid));
            check_value("held rdata", held, rdata);
            check_value("req_ready", dport_word_t'(0), dport_word_t'(req_ready));
        end
        // Response must stay with hart 1 after the select moves
        @(posedge clk);
        hartsel <= hart_idx_t'(3);
        repeat (3) begin
            @(negedge clk);
            check_value("owner valid", dport_word_t'(1), dport_word_t'(resp_valid));
            check_value("owner error", dport_word_t'(exp_err), dport_word_t'(resp_error));
            check_value("owner rdata", exp_data, rdata);
        end
        @(posedge clk);
        resp_ready <= 1'b1;
        @(negedge clk);
        @(negedge clk);
        check_value("valid after release", dport_word_t'(0), dport_word_t'(resp_valid));
    end
    @(posedge clk);
    resp_ready <= 1'b1;
    end_test();
endtask

task automatic test_hart_reset();
    dport_word_t r;
    begin_test("hart_reset");
    r = dport_word_t'(1 + rand32() % 31);
    pulse_run_control(hart_idx_t'(0), 1'b1, 1'b0, 1'b0, 1'b0);
    run_access(hart_idx_t'(0), TYPE_WRITE, r, rand64(), 3'd3);
    run_access(hart_idx_t'(0), TYPE_READ, r, '0, 3'd3);
    pulse_run_control(hart_idx_t'(0), 1'b0, 1'b0, 1'b1, 1'b0);
    pulse_run_control(hart_idx_t'(0), 1'b0, 1'b0, 1'b0, 1'b1);
    run_access(hart_idx_t'(0), TYPE_READ, STATUS, '0, 3'd3);  // Halted with flag
    run_access(hart_idx_t'(0), TYPE_READ, r, '0, 3'd3);
    // No flag on hart 2, so it comes out of reset running
    pulse_run_control(hart_idx_t'(2), 1'b1, 1'b0, 1'b0, 1'b0);
    run_access(hart_idx_t'(2), TYPE_WRITE, r, rand64(), 3'd3);
    pulse_run_control(hart_idx_t'(2), 1'b0, 1'b0, 1'b0, 1'b1);
    run_access(hart_idx_t'(2), TYPE_READ, r, '0, 3'd3);
    pulse_run_control(hart_idx_t'(2), 1'b1, 1'b0, 1'b0, 1'b0);
    run_access(hart_idx_t'(2), TYPE_READ, r, '0, 3'd3);
    run_access(hart_idx_t'(2), TYPE_READ, STATUS, '0, 3'd3);
    end_test();
endtask

`endif

//--- testbench/tb_dport_cluster.sv
/* Directed testbench for the debug port cluster
   Drives the debug request port and checks each response against a model */

`timescale 1ns/1ps
`default_nettype none

`include "dport_consts.svh"

module tb_dport_cluster;

    import dport_cfg_pkg::*;
    import dport_proto_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int RESP_WAIT    = 20;    // Handshake wait before giving up
    // Roughly 120 accesses of 4 cycles and some run control in about 550 cycles
    localparam int CYCLE_LIMIT  = 4000;

    localparam dport_type_t TYPE_NOP   = 2'b00;
    localparam dport_type_t TYPE_READ  = 2'b10;
    localparam dport_type_t TYPE_WRITE = 2'b11;
    localparam dport_word_t STATUS     = dport_word_t'(`DPORT_STATUS_ADDR);

    logic        clk;
    logic        nrst;
    hart_idx_t   hartsel;
    logic        haltreq;
    logic        resumereq;
    logic        resethaltreq;
    logic        hartreset;
    logic        req_valid;
    dport_type_t req_type;
    dport_word_t addr;
    dport_word_t wdata;
    dport_size_t size;
    logic        resp_ready;
    logic        req_ready;
    logic        resp_valid;
    logic        resp_error;
    dport_word_t rdata;

    // Reference model of every hart
    dport_word_t model_gpr [`DPORT_HART_COUNT][`DPORT_GPR_COUNT];
    logic        model_halted [`DPORT_HART_COUNT];
    logic        model_flag [`DPORT_HART_COUNT];

    int          error_count = 0;
    int          check_count = 0;
    int          test_count  = 0;
    int          test_first_error = 0;
    int          cycle_count = 0;
    string       test_name = "";
    logic [31:0] rng_state = 32'h2f0e;

    dport_cluster dport_cluster_inst (
        .i_clk          (clk),
        .i_nrst         (nrst),
        .i_hartsel      (hartsel),
        .i_haltreq      (haltreq),
        .i_resumereq    (resumereq),
        .i_resethaltreq (resethaltreq),
        .i_hartreset    (hartreset),
        .i_req_valid    (req_valid),
        .i_req_type     (req_type),
        .i_addr         (addr),
        .i_wdata        (wdata),
        .i_size         (size),
        .i_resp_ready   (resp_ready),
        .o_req_ready    (req_ready),
        .o_resp_valid   (resp_valid),
        .o_resp_error   (resp_error),
        .o_rdata        (rdata)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Run stopped at cycle %0d, the test sequence did not finish", cycle_count);
            $display("Errors found");
            $finish;
        end
    end

    task automatic check_value(input string what, input dport_word_t expected,
                               input dport_word_t actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("** Error: %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("Test %s: %s", test_name, msg);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_first_error = error_count;
        test_count++;
    endtask

    task automatic end_test();
        if (error_count == test_first_error) begin
            $display("Test %s passed", test_name);
        end else begin
            $display("Test %s failed with %0d problems", test_name,
                     error_count - test_first_error);
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic dport_word_t rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = rand32();
        lo = rand32();
        return {hi, lo};
    endfunction

    `include "tb_dport_tests.svh"

    initial begin
        nrst         <= 1'b0;
        hartsel      <= '0;
        haltreq      <= 1'b0;
        resumereq    <= 1'b0;
        resethaltreq <= 1'b0;
        hartreset    <= 1'b0;
        req_valid    <= 1'b0;
        req_type     <= TYPE_NOP;
        addr         <= '0;
        wdata        <= '0;
        size         <= '0;
        resp_ready   <= 1'b1;
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);

        test_reset_status();
        test_halt_one();
        test_sized_access();
        test_access_errors();
        test_backpressure();
        test_hart_reset();

        $display("Tests run: %0d, checks: %0d, failures: %0d",
                 test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+logic
+incdir+testbench
logic/dport_cfg_pkg.sv
logic/dport_proto_pkg.sv
logic/dport_ic.sv
logic/hart_debug_ctrl.sv
logic/dport_cluster.sv
testbench/tb_dport_cluster.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -sv
TOP       = tb_dport_cluster
FILELIST  = list.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Errors found

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard logic/*.sv logic/*.svh testbench/*.sv testbench/*.svh)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -sv -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
